//--- tb/rv_cases.txt
# P <addr> <instr>         program word served at that fetch address, hex
# R <pc> <rd> <value>      expected retire records in order, hex
P 00 00500093  addi x1, x0, 5
P 04 ffd00113  addi x2, x0, -3
P 08 402081b3  sub x3, x1, x2
P 0c 40115213  srai x4, x2, 1
P 10 001122b3  slt x5, x2, x1
P 14 00113333  sltu x6, x2, x1
P 18 800003b7  lui x7, 0x80000
P 1c 00001417  auipc x8, 1
P 20 00303823  sd x3, 16(x0)
P 24 01003483  ld x9, 16(x0)
P 28 00208463  beq x1, x2, +8 not taken
P 2c 00209463  bne x1, x2, +8 taken
P 34 00114463  blt x2, x1, +8 taken
P 3c 00115463  bge x2, x1, +8 not taken
P 40 008005ef  jal x11, +8
P 48 05400667  jalr x12, 0x54(x0)
P 54 00708013  addi x0, x1, 7
P 58 001006b3  add x13, x0, x1
P 5c 00000073  ecall
R 00 01 0000000000000005
R 04 02 fffffffffffffffd
R 08 03 0000000000000008
R 0c 04 fffffffffffffffe
R 10 05 0000000000000001
R 14 06 0000000000000000
R 18 07 ffffffff80000000
R 1c 08 000000000000101c
R 20 00 0000000000000000
R 24 09 0000000000000008
R 28 00 0000000000000000
R 2c 00 0000000000000000
R 34 00 0000000000000000
R 3c 00 0000000000000000
R 40 0b 0000000000000044
R 48 0c 000000000000004c
R 54 00 000000000000000c
R 58 0d 0000000000000005
R 5c 00 0000000000000000

//--- project.f
common/isa_pkg.sv
common/core_pkg.sv
datapath/reg_file.sv
datapath/alu.sv
datapath/imm_gen.sv
verilog/data_mem.sv
verilog/control_unit.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = tb_rv_core
FILELIST = project.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_rv_core.sv
`timescale 1ns/1ns
module tb_rv_core;
    import isa_pkg::*;
    import core_pkg::*;

    logic            clk = 1'b0;
    logic            rst;
    logic            ifetch_req;
    logic [xlen-1:0] ifetch_addr;
    logic            ifetch_ack;
    instr_t          ifetch_data;
    retire_t         retire;
    logic            finished;

    // program image and expected retire trace
    logic [63:0] prog_addr [64];
    logic [31:0] prog_word [64];
    logic [63:0] exp_pc [64];
    logic [4:0]  exp_rd [64];
    logic [63:0] exp_val [64];
    int          n_prog = 0;
    int          n_rec = 0;
    int          rec_idx = 0;
    logic        cases_loaded = 1'b0;

    int          errors = 0;
    int          failures = 0;
    logic [31:0] lfsr = 32'h3d7e;

    rv_core dut (
        .clk         (clk),
        .rst         (rst),
        .ifetch_req  (ifetch_req),
        .ifetch_addr (ifetch_addr),
        .ifetch_ack  (ifetch_ack),
        .ifetch_data (ifetch_data),
        .retire      (retire),
        .finished    (finished)
    );

    always #5 clk = ~clk;

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two bits taken with one step per bit
    task automatic next_delay(output int d);
        lfsr = lfsr_step(lfsr);
        d = int'(lfsr[0]);
        lfsr = lfsr_step(lfsr);
        d = d + 2 * int'(lfsr[0]);
    endtask

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // -1 when no program word sits at addr
    function automatic int find_word(input logic [63:0] addr);
        int k;
        find_word = -1;
        for (k = 0; k < n_prog; k++) begin
            if (prog_addr[k] == addr) begin
                find_word = k;
            end
        end
    endfunction

    // keeps P and R lines and skips anything else
    task automatic load_cases();
        int              fd;
        int              n;
        reg [8*128-1:0]  line;
        reg [7:0]        tag;
        logic [63:0]     f1;
        logic [63:0]     f2;
        logic [63:0]     f3;
        fd = $fopen("tb/rv_cases.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("cannot open tb/rv_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                tag = 8'd0;
                if ($fgets(line, fd) > 0) begin
                    n = $sscanf(line, "%s %h %h %h", tag, f1, f2, f3);
                    if (tag == "P" && n >= 3 && n_prog < 64) begin
                        prog_addr[n_prog] = f1;
                        prog_word[n_prog] = f2[31:0];
                        n_prog++;
                    end else if (tag == "R" && n >= 4 && n_rec < 64) begin
                        exp_pc[n_rec] = f1;
                        exp_rd[n_rec] = f2[4:0];
                        exp_val[n_rec] = f3;
                        n_rec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // instruction memory behind the four-phase fetch port
    initial begin : fetch_server
        int d;
        int k;
        ifetch_ack = 1'b0;
        ifetch_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && ifetch_req) begin
                // fetch address follows the expected pc trace
                if (rec_idx < n_rec) begin
                    check_eq("ifetch_addr", exp_pc[rec_idx], ifetch_addr);
                end
                next_delay(d);
                repeat (d) begin
                    @(posedge clk);
                    #1;
                end
                k = find_word(ifetch_addr);
                if (k < 0) begin
                    failures++;
                    $display("fetch from address %h has no program word", ifetch_addr);
                    // feed an ecall so the core halts
                    ifetch_data = 32'h0000_0073;
                end else begin
                    ifetch_data = prog_word[k];
                end
                ifetch_ack = 1'b1;
                // hold ack until req drops
                do begin
                    @(posedge clk);
                    #1;
                end while (ifetch_req);
                ifetch_ack = 1'b0;
            end
        end
    end

    // compare each retire pulse with the next record
    initial begin : retire_monitor
        forever begin
            @(posedge clk);
            #1;
            if (!rst && retire.valid) begin
                if (rec_idx >= n_rec) begin
                    failures++;
                    $display("retire at pc %h with no expected record left", retire.pc);
                end else begin
                    check_eq("retire.pc", exp_pc[rec_idx], retire.pc);
                    check_eq("retire.rd", 64'(exp_rd[rec_idx]), 64'(retire.rd));
                    check_eq("retire.value", exp_val[rec_idx], retire.value);
                    rec_idx++;
                end
            end
        end
    end

    // 20 cycles per expected record
    initial begin : watchdog
        int limit;
        wait (cases_loaded === 1'b1 && rst === 1'b0);
        limit = n_rec * 20 * 10;
        #(limit);
        $display("timeout: core did not halt within %0d ns", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_flow
        rst = 1'b1;
        load_cases();
        cases_loaded = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        while (finished !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        // halted core keeps the fetch port quiet and finished high
        repeat (8) begin
            @(posedge clk);
            #1;
            check_eq("ifetch_req", 64'd0, 64'(ifetch_req));
            check_eq("finished", 64'd1, 64'(finished));
        end
        if (rec_idx != n_rec) begin
            failures++;
            $display("halted with %0d expected retire records missing", n_rec - rec_idx);
        end
        $display("errors: %0d mismatches, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ns
module rv_core (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     ifetch_req,
    output logic [isa_pkg::xlen-1:0] ifetch_addr,
    input  logic                     ifetch_ack,
    input  isa_pkg::instr_t          ifetch_data,
    output core_pkg::retire_t        retire,
    output logic                     finished
);
    import isa_pkg::*;
    import core_pkg::*;

    // data port
    dmem_req_t       dmem;
    logic            dmem_ack;
    logic [xlen-1:0] dmem_rdata;

    // register file port
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;

    // alu and immediate
    instr_t          instr;
    logic [xlen-1:0] imm;
    alu_op_t         alu_op;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic            br_taken;

    control_unit u_cu (
        .clk         (clk),
        .rst         (rst),
        .ifetch_req  (ifetch_req),
        .ifetch_addr (ifetch_addr),
        .ifetch_ack  (ifetch_ack),
        .ifetch_data (ifetch_data),
        .dmem        (dmem),
        .dmem_ack    (dmem_ack),
        .dmem_rdata  (dmem_rdata),
        .instr       (instr),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_y       (alu_y),
        .br_taken    (br_taken),
        .retire      (retire),
        .finished    (finished)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    // branch condition comes from the latched funct3
    alu u_alu (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .funct3   (instr.r.funct3),
        .y        (alu_y),
        .br_taken (br_taken)
    );

    imm_gen u_imm (
        .instr (instr),
        .imm   (imm)
    );

    data_mem u_dmem (
        .clk   (clk),
        .rst   (rst),
        .req   (dmem),
        .ack   (dmem_ack),
        .rdata (dmem_rdata)
    );

endmodule

//--- verilog/control_unit.sv
`timescale 1ns/1ns
module control_unit (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     ifetch_req,
    output logic [isa_pkg::xlen-1:0] ifetch_addr,
    input  logic                     ifetch_ack,
    input  isa_pkg::instr_t          ifetch_data,
    output core_pkg::dmem_req_t      dmem,
    input  logic                     dmem_ack,
    input  logic [isa_pkg::xlen-1:0] dmem_rdata,
    output isa_pkg::instr_t          instr,
    output logic [4:0]               rs1_idx,
    output logic [4:0]               rs2_idx,
    input  logic [isa_pkg::xlen-1:0] rs1_val,
    input  logic [isa_pkg::xlen-1:0] rs2_val,
    output logic                     rf_we,
    output logic [4:0]               rf_waddr,
    output logic [isa_pkg::xlen-1:0] rf_wdata,
    input  logic [isa_pkg::xlen-1:0] imm,
    output core_pkg::alu_op_t        alu_op,
    output logic [isa_pkg::xlen-1:0] alu_a,
    output logic [isa_pkg::xlen-1:0] alu_b,
    input  logic [isa_pkg::xlen-1:0] alu_y,
    input  logic                     br_taken,
    output core_pkg::retire_t        retire,
    output logic                     finished
);
    import isa_pkg::*;
    import core_pkg::*;

    cu_state_t       state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] npc_q;
    logic [xlen-1:0] a_q;
    logic [xlen-1:0] b_q;
    logic [xlen-1:0] res_q;
    instr_t          ir;
    logic [6:0]      opc;
    logic            has_rd;
    logic            mem_got;

    // everything decodes from the latched word
    assign opc = ir.r.opcode;
    assign instr = ir;
    assign rs1_idx = ir.r.rs1;
    assign rs2_idx = ir.r.rs2;
    assign ifetch_addr = pc;
    assign pc_plus4 = pc + xlen'(ilen / 8);
    // no rd for stores and branches
    assign has_rd = (opc != op_store) && (opc != op_branch);

    // alu operands and op from opcode
    always_comb begin
        alu_a = a_q;
        alu_b = imm;
        alu_op = alu_add;
        case (opc)
            op_r, op_imm: begin
                if (opc == op_r) begin
                    alu_b = b_q;
                end
                case (ir.r.funct3)
                    f3_add:  alu_op = (opc == op_r && ir.r.funct7[5]) ? alu_sub : alu_add;
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    // bit 30 picks arithmetic shift, also for srai
                    f3_srl:  alu_op = ir.r.funct7[5] ? alu_sra : alu_srl;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: alu_op = alu_add;
                endcase
            end
            // comparator only, on rs1 and rs2
            op_branch: alu_b = b_q;
            op_lui:    alu_a = '0;
            op_auipc:  alu_a = pc;
            default: ;
        endcase
    end

    // next pc, valid in s_execute
    always_comb begin
        case (opc)
            op_branch: pc_next = br_taken ? pc + imm : pc_plus4;
            op_jal:    pc_next = pc + imm;
            // jalr target is rs1 + imm with bit 0 cleared
            op_jalr:   pc_next = alu_y & ~xlen'(1);
            default:   pc_next = pc_plus4;
        endcase
    end

    // data request drops as soon as ack is seen
    assign dmem.req = (state == s_mem) ||
                      (state == s_mem_wait && !mem_got && !dmem_ack);
    assign dmem.we = (opc == op_store);
    assign dmem.addr = res_q;
    assign dmem.wdata = b_q;

    // write-back port
    assign rf_we = (state == s_writeback) && has_rd;
    assign rf_waddr = ir.r.rd;
    assign rf_wdata = res_q;

    // retire pulse in writeback, or first halt cycle for ecall
    assign retire.valid = (state == s_writeback) || (state == s_halt && !finished);
    assign retire.pc = pc;
    assign retire.rd = (state == s_writeback && has_rd) ? ir.r.rd : 5'd0;
    assign retire.value = (state == s_writeback && has_rd) ? res_q : '0;

    // fsm, pc and handshake flags
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_fetch;
            pc <= '0;
            ifetch_req <= 1'b0;
            mem_got <= 1'b0;
            finished <= 1'b0;
        end else begin
            case (state)
                s_fetch: begin
                    ifetch_req <= 1'b1;
                    state <= s_fetch_wait;
                end
                s_fetch_wait: begin
                    // drop req on ack, leave once ack is low again
                    if (ifetch_req && ifetch_ack) begin
                        ifetch_req <= 1'b0;
                    end else if (!ifetch_req && !ifetch_ack) begin
                        state <= s_decode;
                    end
                end
                s_decode: state <= s_execute;
                s_execute: begin
                    mem_got <= 1'b0;
                    if (opc == op_system) begin
                        state <= s_halt;
                    end else if (opc == op_load || opc == op_store) begin
                        state <= s_mem;
                    end else begin
                        state <= s_writeback;
                    end
                end
                s_mem: state <= s_mem_wait;
                s_mem_wait: begin
                    if (!mem_got && dmem_ack) begin
                        mem_got <= 1'b1;
                    end else if (mem_got && !dmem_ack) begin
                        state <= s_writeback;
                    end
                end
                s_writeback: begin
                    pc <= npc_q;
                    state <= s_fetch;
                end
                // halted for good
                default: finished <= 1'b1;
            endcase
        end
    end

    // instruction, operand and result registers
    always_ff @(posedge clk) begin
        if (state == s_fetch_wait && ifetch_req && ifetch_ack) begin
            ir <= ifetch_data;
        end
        if (state == s_decode) begin
            a_q <= rs1_val;
            b_q <= rs2_val;
        end
        if (state == s_execute) begin
            // jumps link pc + 4, the rest keep the alu result
            res_q <= (opc == op_jal || opc == op_jalr) ? pc_plus4 : alu_y;
            npc_q <= pc_next;
        end
        if (state == s_mem_wait && !mem_got && dmem_ack && !dmem.we) begin
            res_q <= dmem_rdata;
        end
    end

    // fetch and data traffic never overlap
    assert property (@(posedge clk) disable iff (rst) !(ifetch_req && dmem.req));

    // every data access is an aligned doubleword inside memory
    assert property (@(posedge clk) disable iff (rst)
        dmem.req |-> (dmem.addr[2:0] == 3'd0) && (dmem.addr < xlen'(dmem_depth * 8)));

endmodule

//--- verilog/data_mem.sv
`timescale 1ns/1ns
module data_mem (
    input  logic                     clk,
    input  logic                     rst,
    input  core_pkg::dmem_req_t      req,
    output logic                     ack,
    output logic [isa_pkg::xlen-1:0] rdata
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [xlen-1:0]    mem [dmem_depth];
    logic [dmem_aw-1:0] idx;

    // doubleword index, low three bits are the byte offset
    assign idx = req.addr[dmem_aw+2:3];

    // four-phase slave, one cycle per edge
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            rdata <= '0;
            for (int k = 0; k < dmem_depth; k++) begin
                mem[k] <= '0;
            end
        end else if (req.req && !ack) begin
            // access happens as ack rises
            ack <= 1'b1;
            rdata <= mem[idx];
            if (req.we) begin
                mem[idx] <= req.wdata;
            end
        end else if (!req.req && ack) begin
            ack <= 1'b0;
        end
    end

    // master holds the payload while ack is up
    assert property (@(posedge clk) disable iff (rst)
        ack |-> $stable({req.we, req.addr, req.wdata}));

endmodule

//--- datapath/imm_gen.sv
`timescale 1ns/1ns
module imm_gen (
    input  isa_pkg::instr_t          instr,
    output logic [isa_pkg::xlen-1:0] imm
);
    import isa_pkg::*;

    // opcode sits in the same bits for every format
    always_comb begin
        case (instr.r.opcode)
            op_imm, op_load, op_jalr, op_system: begin
                imm = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
            end
            op_store: begin
                imm = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            // branch offsets are even
            op_branch: begin
                imm = {{(xlen-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            // upper immediate, sign taken from bit 31
            op_lui, op_auipc: begin
                imm = {{(xlen-32){instr.u.imm[19]}}, instr.u.imm, 12'd0};
            end
            op_jal: begin
                imm = {{(xlen-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

//--- datapath/alu.sv
`timescale 1ns/1ns
module alu (
    input  core_pkg::alu_op_t        op,
    input  logic [isa_pkg::xlen-1:0] a,
    input  logic [isa_pkg::xlen-1:0] b,
    input  logic [2:0]               funct3,
    output logic [isa_pkg::xlen-1:0] y,
    output logic                     br_taken
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [5:0] shamt;

    // rv64 shifts use six bits
    assign shamt = b[5:0];

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_and:  y = a & b;
            alu_or:   y = a | b;
            alu_xor:  y = a ^ b;
            alu_sll:  y = a << shamt;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = $signed(a) >>> shamt;
            alu_slt:  y = xlen'($signed(a) < $signed(b));
            alu_sltu: y = xlen'(a < b);
            default:  y = '0;
        endcase
    end

    // branch compare on rs1, rs2
    always_comb begin
        case (funct3)
            f3_beq:  br_taken = (a == b);
            f3_bne:  br_taken = (a != b);
            f3_blt:  br_taken = ($signed(a) < $signed(b));
            f3_bge:  br_taken = ($signed(a) >= $signed(b));
            default: br_taken = 1'b0;
        endcase
    end

endmodule

//--- datapath/reg_file.sv
`timescale 1ns/1ns
module reg_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4:0]               rs1_idx,
    input  logic [4:0]               rs2_idx,
    output logic [isa_pkg::xlen-1:0] rs1_val,
    output logic [isa_pkg::xlen-1:0] rs2_val,
    input  logic                     we,
    input  logic [4:0]               waddr,
    input  logic [isa_pkg::xlen-1:0] wdata
);
    import isa_pkg::*;

    logic [xlen-1:0] regs [32];

    // two async read ports
    assign rs1_val = regs[rs1_idx];
    assign rs2_val = regs[rs2_idx];

    // one write port that never touches x0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // both read ports see zero for x0
    assert property (@(posedge clk) disable iff (rst)
        (rs1_idx != 5'd0 || rs1_val == '0) && (rs2_idx != 5'd0 || rs2_val == '0));

endmodule

//--- common/core_pkg.sv
package core_pkg;

    // multicycle fsm states
    typedef enum logic [2:0] {
        s_fetch,
        s_fetch_wait,
        s_decode,
        s_execute,
        s_mem,
        s_mem_wait,
        s_writeback,
        s_halt
    } cu_state_t;

    // alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    // control unit to data memory
    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [isa_pkg::xlen-1:0] addr;
        logic [isa_pkg::xlen-1:0] wdata;
    } dmem_req_t;

    // one record per retired instruction
    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::xlen-1:0] pc;
        logic [4:0]               rd;
        logic [isa_pkg::xlen-1:0] value;
    } retire_t;

    // data memory size in doublewords
    localparam int dmem_depth = 256;
    localparam int dmem_aw = $clog2(dmem_depth);

endpackage

//--- common/isa_pkg.sv
package isa_pkg;

    // data and instruction widths
    localparam int xlen = 64;
    localparam int ilen = 32;

    // major opcodes
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    // alu funct3, add/sub and srl/sra share a code
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage
